/* dv/lsu_tb.sv */
`default_nettype none

module lsu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS   = 256;
    localparam int MEM_BYTES   = MEM_WORDS * 8;
    localparam int STORE_TESTS = 32;   // Each followed by an LD
    localparam int LOAD_TESTS  = 56;
    localparam int OOR_TESTS   = 16;   // Each followed by an LD of the aliased doubleword
    localparam int STREAM_REQS = 200;
    localparam int NUM_REQS    = MEM_WORDS + 2 * STORE_TESTS + LOAD_TESTS + 2 * OOR_TESTS
                                 + STREAM_REQS;
    localparam int MAX_CYCLES  = 40 * NUM_REQS + 200;

    logic               clk = 1'b0;
    logic               rst;
    logic               req_valid;
    logic               req_ready;
    lsu_pkg::lsu_req_t  req;
    logic               resp_valid;
    logic               resp_ready = 1'b1;
    lsu_pkg::lsu_resp_t resp;

    lsu_pkg::xlen_t     model [MEM_WORDS];  // Mirror of the RAM contents
    lsu_pkg::lsu_resp_t exp_q [$];           // Predicted responses in request order
    int                 cycles = 0;
    logic               stall_en = 1'b0;
    logic               held_prev = 1'b0;
    lsu_pkg::lsu_resp_t held_resp;

    lsu_top #(.MEM_WORDS(MEM_WORDS)) u_dut (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp(resp)
    );

    always #20 clk = ~clk;

    task automatic fatal_stop();
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        fatal_stop();
    endtask

    task automatic value_error(input string name, input lsu_pkg::xlen_t expected,
                               input lsu_pkg::xlen_t actual);
        $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
        fatal_stop();
    endtask

    // Gather the accessed bytes, then extend from the top byte for signed kinds
    function automatic lsu_pkg::xlen_t load_value(input logic [2:0] funct3,
                                                   input lsu_pkg::addr_t addr);
        lsu_pkg::xlen_t word;
        lsu_pkg::xlen_t val;
        int             nbytes;
        int             off;
        word   = model[addr[10:3]];
        nbytes = 1 << funct3[1:0];
        off    = int'(addr[2:0]);
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = word[8*(off+i) +: 8];
        end
        if (!funct3[2] && nbytes < 8 && val[8*nbytes-1]) begin
            for (int i = nbytes; i < 8; i++) begin
                val[8*i +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    function automatic void store_update(input logic [2:0] funct3, input lsu_pkg::addr_t addr,
                                         input lsu_pkg::xlen_t wdata);
        int nbytes;
        int off;
        nbytes = 1 << funct3[1:0];
        off    = int'(addr[2:0]);
        for (int i = 0; i < nbytes; i++) begin
            model[addr[10:3]][8*(off+i) +: 8] = wdata[8*i +: 8];  // Low bytes of wdata only
        end
    endfunction

    function automatic void predict(input lsu_pkg::lsu_req_t r);
        lsu_pkg::lsu_resp_t e;
        e.err   = (r.addr >= MEM_BYTES);
        e.rdata = '0;
        if (!e.err && r.is_store) begin
            store_update(r.funct3, r.addr, r.wdata);
        end else if (!e.err) begin
            e.rdata = load_value(r.funct3, r.addr);
        end
        exp_q.push_back(e);
    endfunction

    function automatic lsu_pkg::addr_t aligned_addr(input logic [2:0] funct3,
                                                    input int unsigned span);
        lsu_pkg::addr_t a;
        a = $urandom % span;
        return a & ~((32'd1 << funct3[1:0]) - 32'd1);
    endfunction

    function automatic lsu_pkg::xlen_t random_word();
        return {$urandom, $urandom};
    endfunction

    // Starts and returns 2 ns after a rising edge
    task automatic send_req(input logic is_store, input logic [2:0] funct3,
                            input lsu_pkg::addr_t addr, input lsu_pkg::xlen_t wdata);
        lsu_pkg::lsu_req_t r;
        r.is_store = is_store;
        r.funct3   = funct3;
        r.addr     = addr;
        r.wdata    = wdata;
        req        = r;
        req_valid  = 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        predict(r);  // Taken on the coming edge
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    always @(posedge clk) begin
        #2;
        resp_ready = stall_en ? ($urandom % 4 != 0) : 1'b1;
    end

    // Sampled mid-cycle where inputs and DUT outputs have settled
    always @(negedge clk) begin
        lsu_pkg::lsu_resp_t exp_resp;
        if (!rst) begin
            if (held_prev) begin
                assert (resp_valid) else report_error("resp_valid dropped while stalled");
                assert (resp.rdata == held_resp.rdata)
                    else value_error("resp.rdata", held_resp.rdata, resp.rdata);
                assert (resp.err == held_resp.err)
                    else value_error("resp.err", {63'd0, held_resp.err}, {63'd0, resp.err});
            end
            if (resp_valid && resp_ready) begin
                assert (exp_q.size() > 0) else report_error("response with no request pending");
                exp_resp = exp_q.pop_front();
                assert (resp.rdata == exp_resp.rdata)
                    else value_error("resp.rdata", exp_resp.rdata, resp.rdata);
                assert (resp.err == exp_resp.err)
                    else value_error("resp.err", {63'd0, exp_resp.err}, {63'd0, resp.err});
            end
            held_prev = resp_valid && !resp_ready;
            held_resp = resp;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            fatal_stop();
        end
    end

    initial begin
        lsu_pkg::addr_t a;
        logic [2:0]     f3;
        logic           st;
        void'($urandom(32'h36db));
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        repeat (3) begin
            @(negedge clk);
            assert (!resp_valid) else value_error("resp_valid", 64'd0, {63'd0, resp_valid});
            assert (req_ready) else value_error("req_ready", 64'd1, {63'd0, req_ready});
        end
        @(posedge clk);
        #2;

        // Random fill of the whole memory
        for (int i = 0; i < MEM_WORDS; i++) begin
            send_req(1'b1, 3'b011, lsu_pkg::addr_t'(i * 8), random_word());
        end
        drain();

        for (int i = 0; i < STORE_TESTS; i++) begin
            f3 = 3'(i % 4);
            a  = aligned_addr(f3, MEM_BYTES);
            send_req(1'b1, f3, a, random_word());
            send_req(1'b0, 3'b011, a & ~32'h7, '0);
        end
        drain();

        for (int i = 0; i < LOAD_TESTS; i++) begin
            f3 = 3'(i % 7);  // LB LH LW LD LBU LHU LWU
            send_req(1'b0, f3, aligned_addr(f3, MEM_BYTES), '0);
        end
        drain();

        for (int i = 0; i < OOR_TESTS; i++) begin
            st = i[0];
            f3 = st ? 3'($urandom % 4) : 3'($urandom % 7);
            a  = 32'(MEM_BYTES) + aligned_addr(f3, 4096);
            send_req(st, f3, a, random_word());
            send_req(1'b0, 3'b011, a & 32'h7f8, '0);
        end
        drain();

        // Back to back with random back-pressure
        stall_en = 1'b1;
        for (int i = 0; i < STREAM_REQS; i++) begin
            st = 1'($urandom % 2);
            f3 = st ? 3'($urandom % 4) : 3'($urandom % 7);
            a  = aligned_addr(f3, MEM_BYTES);
            if ($urandom % 8 == 0) begin
                a = a + 32'(MEM_BYTES);
            end
            send_req(st, f3, a, random_word());
        end
        drain();
        stall_en = 1'b0;

        // A duplicated response would surface here with nothing left to match
        repeat (4) @(negedge clk);
        assert (!resp_valid) else value_error("resp_valid", 64'd0, {63'd0, resp_valid});
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [63:0] axi_data_t;
    typedef logic [7:0]  axi_strb_t;
    typedef logic [2:0]  axi_prot_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // Payloads only, valid and ready are separate ports
    typedef struct packed {
        axi_addr_t addr;
        axi_prot_t prot;
    } axi_aw_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
    } axi_w_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

    typedef struct packed {
        axi_addr_t addr;
        axi_prot_t prot;
    } axi_ar_t;

    typedef struct packed {
        axi_data_t data;
        axi_resp_e resp;
    } axi_r_t;

endpackage

`default_nettype wire

/* logic/axi_lite_ram.sv */
`default_nettype none

module axi_lite_ram #(
    parameter int MEM_WORDS = 256
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   awvalid,
    output logic                        awready,
    input  wire axi_lite_pkg::axi_aw_t  aw,
    input  wire logic                   wvalid,
    output logic                        wready,
    input  wire axi_lite_pkg::axi_w_t   w,
    output logic                        bvalid,
    input  wire logic                   bready,
    output axi_lite_pkg::axi_b_t        b,
    input  wire logic                   arvalid,
    output logic                        arready,
    input  wire axi_lite_pkg::axi_ar_t  ar,
    output logic                        rvalid,
    input  wire logic                   rready,
    output axi_lite_pkg::axi_r_t        r
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam axi_lite_pkg::axi_addr_t MEM_BYTES = MEM_WORDS * 8;

    axi_lite_pkg::axi_data_t mem [MEM_WORDS];

    logic                    aw_held;
    logic                    w_held;
    axi_lite_pkg::axi_addr_t waddr;
    axi_lite_pkg::axi_w_t    wbeat;
    logic                    write_go;
    logic                    waddr_ok;
    logic                    raddr_ok;

    assign awready  = !aw_held && !bvalid;
    assign wready   = !w_held && !bvalid;
    assign arready  = !rvalid;
    assign write_go = aw_held && w_held;  // Both channels in, commit next edge
    assign waddr_ok = waddr < MEM_BYTES;
    assign raddr_ok = ar.addr < MEM_BYTES;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (write_go) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
            end else begin
                if (awvalid && awready) aw_held <= 1'b1;
                if (wvalid && wready)   w_held  <= 1'b1;
            end
            if (bvalid && bready) bvalid <= 1'b0;
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) waddr <= aw.addr;
        if (wvalid && wready)   wbeat <= w;
        if (write_go) begin
            b.resp <= waddr_ok ? axi_lite_pkg::OKAY : axi_lite_pkg::SLVERR;
            if (waddr_ok) begin
                for (int i = 0; i < 8; i++) begin
                    if (wbeat.strb[i]) mem[waddr[IDX_W+2:3]][8*i +: 8] <= wbeat.data[8*i +: 8];
                end
            end
        end
        if (arvalid && arready) begin
            r.data <= raddr_ok ? mem[ar.addr[IDX_W+2:3]] : '0;  // Out of range reads zero
            r.resp <= raddr_ok ? axi_lite_pkg::OKAY : axi_lite_pkg::SLVERR;
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_bus_stage.sv */
`default_nettype none

module lsu_bus_stage (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   in_valid,
    input  wire lsu_pkg::lsu_bus_req_t  in_req,
    output logic                        in_ready,
    output logic                        out_valid,
    output logic                        out_is_store,
    output logic [2:0]                  out_funct3,
    output logic [2:0]                  out_offset,
    output lsu_pkg::xlen_t              out_rdata,
    output logic                        out_err,
    input  wire logic                   out_ready,
    output logic                        awvalid,
    input  wire logic                   awready,
    output axi_lite_pkg::axi_aw_t       aw,
    output logic                        wvalid,
    input  wire logic                   wready,
    output axi_lite_pkg::axi_w_t        w,
    input  wire logic                   bvalid,
    output logic                        bready,
    input  wire axi_lite_pkg::axi_b_t   b,
    output logic                        arvalid,
    input  wire logic                   arready,
    output axi_lite_pkg::axi_ar_t       ar,
    input  wire logic                   rvalid,
    output logic                        rready,
    input  wire axi_lite_pkg::axi_r_t   r
);

    typedef enum logic [1:0] {IDLE, WRITE, READ, HOLD} bus_state_e;

    bus_state_e            state;
    lsu_pkg::lsu_bus_req_t req_q;
    lsu_pkg::xlen_t        rdata_q;
    logic                  err_q;
    logic                  resp_hit;
    lsu_pkg::xlen_t        beat_rdata;
    logic                  beat_err;

    assign in_ready = (state == IDLE);
    assign bready   = (state == WRITE);
    assign rready   = (state == READ);

    assign aw.addr = req_q.addr;
    assign aw.prot = '0;
    assign w.data  = req_q.wdata;
    assign w.strb  = req_q.strb;
    assign ar.addr = req_q.addr;
    assign ar.prot = '0;

    // B or R handshake this cycle
    assign resp_hit   = (state == WRITE && bvalid) || (state == READ && rvalid);
    assign beat_rdata = (state == READ) ? r.data : '0;
    assign beat_err   = (state == READ) ? (r.resp != axi_lite_pkg::OKAY)
                                        : (b.resp != axi_lite_pkg::OKAY);

    // Response goes straight through, or from the hold registers after a stall
    assign out_valid    = resp_hit || (state == HOLD);
    assign out_rdata    = (state == HOLD) ? rdata_q : beat_rdata;
    assign out_err      = (state == HOLD) ? err_q : beat_err;
    assign out_is_store = req_q.is_store;
    assign out_funct3   = req_q.funct3;
    assign out_offset   = req_q.addr[2:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (in_valid) begin
                        if (in_req.is_store) begin
                            state   <= WRITE;
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                        end else begin
                            state   <= READ;
                            arvalid <= 1'b1;
                        end
                    end
                end
                WRITE: begin
                    if (awready) awvalid <= 1'b0;  // AW and W drop independently
                    if (wready)  wvalid  <= 1'b0;
                    if (bvalid)  state   <= out_ready ? IDLE : HOLD;
                end
                READ: begin
                    if (arready) arvalid <= 1'b0;
                    if (rvalid)  state   <= out_ready ? IDLE : HOLD;
                end
                HOLD: begin
                    if (out_ready) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && in_valid) begin
            req_q <= in_req;
        end
        if (resp_hit) begin
            rdata_q <= beat_rdata;
            err_q   <= beat_err;
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  strb_t;

    // {is_store, funct3}, low three bits follow the RISC-V funct3 encoding
    typedef enum logic [3:0] {
        LB  = 4'b0_000,
        LH  = 4'b0_001,
        LW  = 4'b0_010,
        LD  = 4'b0_011,
        LBU = 4'b0_100,
        LHU = 4'b0_101,
        LWU = 4'b0_110,
        SB  = 4'b1_000,
        SH  = 4'b1_001,
        SW  = 4'b1_010,
        SD  = 4'b1_011
    } lsu_op_e;

    typedef struct packed {
        logic       is_store;
        logic [2:0] funct3;
        addr_t      addr;
        xlen_t      wdata;   // Unshifted store data
    } lsu_req_t;

    // Request after strobe generation and lane shift
    typedef struct packed {
        logic       is_store;
        logic [2:0] funct3;
        addr_t      addr;
        xlen_t      wdata;
        strb_t      strb;
    } lsu_bus_req_t;

    typedef struct packed {
        xlen_t rdata;
        logic  err;
    } lsu_resp_t;

endpackage

`default_nettype wire

/* logic/lsu_req_stage.sv */
`default_nettype none

module lsu_req_stage (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  in_valid,
    input  wire lsu_pkg::lsu_req_t     in_req,
    output logic                       in_ready,
    output logic                       out_valid,
    output lsu_pkg::lsu_bus_req_t      out_req,
    input  wire logic                  out_ready
);

    logic                  full;
    lsu_pkg::lsu_bus_req_t entry;
    lsu_pkg::lsu_bus_req_t next_req;
    logic [2:0]            offset;

    assign offset = in_req.addr[2:0];  // Byte lane within the doubleword

    always_comb begin
        next_req.is_store = in_req.is_store;
        next_req.funct3   = in_req.funct3;
        next_req.addr     = in_req.addr;
        next_req.wdata    = in_req.is_store ? (in_req.wdata << {offset, 3'b000}) : '0;

        // Loads fall to the default and carry no strobe
        case (lsu_pkg::lsu_op_e'({in_req.is_store, in_req.funct3}))
            lsu_pkg::SB: next_req.strb = 8'b0000_0001 << offset;
            lsu_pkg::SH: next_req.strb = 8'b0000_0011 << offset;
            lsu_pkg::SW: next_req.strb = 8'b0000_1111 << offset;
            lsu_pkg::SD: next_req.strb = 8'b1111_1111;
            default:     next_req.strb = '0;
        endcase
    end

    // Single entry, refilled in the cycle it drains
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_req   = entry;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            entry <= next_req;
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_resp_stage.sv */
`default_nettype none

module lsu_resp_stage (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            in_valid,
    output logic                 in_ready,
    input  wire logic            in_is_store,
    input  wire logic [2:0]      in_funct3,
    input  wire logic [2:0]      in_offset,
    input  wire lsu_pkg::xlen_t  in_rdata,
    input  wire logic            in_err,
    output logic                 resp_valid,
    output lsu_pkg::lsu_resp_t   resp,
    input  wire logic            resp_ready
);

    logic               full;
    lsu_pkg::xlen_t     shifted;
    lsu_pkg::lsu_resp_t next_resp;

    assign shifted = in_rdata >> {in_offset, 3'b000};  // Addressed byte to bit 0

    always_comb begin
        next_resp.err = in_err;
        case (lsu_pkg::lsu_op_e'({in_is_store, in_funct3}))
            lsu_pkg::LB:  next_resp.rdata = {{56{shifted[7]}}, shifted[7:0]};
            lsu_pkg::LH:  next_resp.rdata = {{48{shifted[15]}}, shifted[15:0]};
            lsu_pkg::LW:  next_resp.rdata = {{32{shifted[31]}}, shifted[31:0]};
            lsu_pkg::LD:  next_resp.rdata = shifted;
            lsu_pkg::LBU: next_resp.rdata = {56'b0, shifted[7:0]};
            lsu_pkg::LHU: next_resp.rdata = {48'b0, shifted[15:0]};
            lsu_pkg::LWU: next_resp.rdata = {32'b0, shifted[31:0]};
            default:      next_resp.rdata = '0;  // Stores
        endcase
    end

    assign in_ready   = !full || resp_ready;
    assign resp_valid = full;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (resp_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) resp <= next_resp;
    end

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
`default_nettype none

module lsu_top #(
    parameter int MEM_WORDS = 256
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                req_valid,
    output logic                     req_ready,
    input  wire lsu_pkg::lsu_req_t   req,
    output logic                     resp_valid,
    input  wire logic                resp_ready,
    output lsu_pkg::lsu_resp_t       resp
);

    logic                  bus_valid;
    logic                  bus_ready;
    lsu_pkg::lsu_bus_req_t bus_req;

    // Bus stage to response stage
    logic           res_valid;
    logic           res_ready;
    logic           res_is_store;
    logic [2:0]     res_funct3;
    logic [2:0]     res_offset;
    lsu_pkg::xlen_t res_rdata;
    logic           res_err;

    logic                  awvalid, awready, wvalid, wready, bvalid, bready;
    logic                  arvalid, arready, rvalid, rready;
    axi_lite_pkg::axi_aw_t aw;
    axi_lite_pkg::axi_w_t  w;
    axi_lite_pkg::axi_b_t  b;
    axi_lite_pkg::axi_ar_t ar;
    axi_lite_pkg::axi_r_t  r;

    lsu_req_stage u_req (
        .clk(clk), .rst(rst),
        .in_valid(req_valid), .in_req(req), .in_ready(req_ready),
        .out_valid(bus_valid), .out_req(bus_req), .out_ready(bus_ready)
    );

    lsu_bus_stage u_bus (
        .clk(clk), .rst(rst),
        .in_valid(bus_valid), .in_req(bus_req), .in_ready(bus_ready),
        .out_valid(res_valid), .out_is_store(res_is_store), .out_funct3(res_funct3),
        .out_offset(res_offset), .out_rdata(res_rdata), .out_err(res_err),
        .out_ready(res_ready),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .b(b),
        .arvalid(arvalid), .arready(arready), .ar(ar),
        .rvalid(rvalid), .rready(rready), .r(r)
    );

    lsu_resp_stage u_resp (
        .clk(clk), .rst(rst),
        .in_valid(res_valid), .in_ready(res_ready), .in_is_store(res_is_store),
        .in_funct3(res_funct3), .in_offset(res_offset), .in_rdata(res_rdata),
        .in_err(res_err),
        .resp_valid(resp_valid), .resp(resp), .resp_ready(resp_ready)
    );

    axi_lite_ram #(.MEM_WORDS(MEM_WORDS)) u_ram (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .b(b),
        .arvalid(arvalid), .arready(arready), .ar(ar),
        .rvalid(rvalid), .rready(rready), .r(r)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module lsu_tb -f src.f -o lsu_tb_sim

# A failing run exits nonzero, so the log decides the result
./obj_dir/lsu_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* src.f */
logic/lsu_pkg.sv
logic/axi_lite_pkg.sv
logic/lsu_req_stage.sv
logic/lsu_bus_stage.sv
logic/lsu_resp_stage.sv
logic/axi_lite_ram.sv
logic/lsu_top.sv
dv/lsu_tb.sv
